// File: compile.f
source/wb_pkg.sv
source/flags_wb.sv
source/branch_resolve_wb.sv
source/repne_halt_wb.sv
source/operand_select_wb.sv
source/commit_validate_wb.sv
source/dcache_write_wb.sv
source/writeback.sv
testbench/writeback_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the writeback stage testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
   -f compile.f \
   --top-module writeback_tb \
   -o writeback_sim

./obj_dir/writeback_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
   echo "simulation reported failures"
   exit 1
fi
echo "simulation finished without failures"

// File: source/branch_resolve_wb.sv
module branch_resolve_wb import wb_pkg::*; (
   input  logic [word_w-1:0] flags,
   input  logic              is_jne,
   input  logic              is_jnbe,
   input  logic              is_cmovc,
   input  logic              ex_ld_gpr2,
   output logic              take_branch,
   output logic              cond_ld_gpr2
);

   logic cf;
   logic zf;
   logic jne_taken;
   logic jnbe_taken;

   assign cf = flags[flag_cf];
   assign zf = flags[flag_zf];

   assign jne_taken  = is_jne & ~zf;
   // above: neither carry nor zero
   assign jnbe_taken = is_jnbe & ~cf & ~zf;

   assign take_branch = jne_taken | jnbe_taken;

   always_comb begin
      if (is_cmovc) begin
         cond_ld_gpr2 = ex_ld_gpr2 & cf;
      end else begin
         cond_ld_gpr2 = ex_ld_gpr2;
      end
   end

   // one condition per micro-op in the control store
   always_comb begin
      a_one_cond: assert (!(is_jne && is_jnbe))
         else $error("branch_resolve_wb: jne and jnbe both set");
   end

endmodule

// File: source/commit_validate_wb.sv
module commit_validate_wb (
   input  logic valid,
   input  logic stall,
   input  logic repne_terminate,
   input  logic is_cmps_second,
   input  logic ex_ld_gpr1,
   input  logic cond_ld_gpr2,
   input  logic ex_dcache_write,
   input  logic ld_gpr3,
   input  logic ld_seg,
   input  logic ld_mm,
   input  logic ld_flags,
   input  logic ld_eip,
   input  logic ld_cs,
   output logic v_ld_gpr1,
   output logic v_ld_gpr2,
   output logic v_ld_gpr3,
   output logic v_ld_seg,
   output logic v_ld_mm,
   output logic v_ld_flags,
   output logic v_ld_eip,
   output logic v_ld_cs,
   output logic v_dcache_req,
   output logic capture
);

   logic ok;
   logic kill;

   // commit only once, in the cycle the write is acked
   assign ok      = valid & ~stall;
   assign capture = ok;

   // terminating cmps keeps only ecx and flags
   assign kill = is_cmps_second & repne_terminate;

   assign v_ld_gpr1  = ok & ex_ld_gpr1 & ~kill;
   assign v_ld_gpr2  = ok & cond_ld_gpr2 & ~kill;
   assign v_ld_gpr3  = ok & ld_gpr3;
   assign v_ld_seg   = ok & ld_seg & ~kill;
   assign v_ld_mm    = ok & ld_mm & ~kill;
   assign v_ld_flags = ok & ld_flags;
   assign v_ld_eip   = ok & ld_eip;
   assign v_ld_cs    = ok & ld_cs;

   // must not depend on stall, stall is built from it
   assign v_dcache_req = valid & ex_dcache_write;

endmodule

// File: source/dcache_write_wb.sv
module dcache_write_wb import wb_pkg::*; (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                write_req,
   input  logic [word_w-1:0]   address,
   input  logic [mm_w-1:0]     data,
   output logic                stall,
   output logic                wb_cyc,
   output logic                wb_stb,
   output logic                wb_we,
   output logic [word_w-1:0]   wb_adr,
   output logic [mm_w-1:0]     wb_dat_o,
   output logic [mm_w/8-1:0]   wb_sel,
   input  logic                wb_ack
);

   logic              pending;
   logic              active;
   logic [word_w-1:0] adr_q;
   logic [mm_w-1:0]   dat_q;

   assign active = write_req | pending;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pending <= 1'b0;
      end else if (wb_ack) begin
         pending <= 1'b0;
      end else if (write_req) begin
         pending <= 1'b1;
      end
   end

   // hold address and data from the first cycle of the cycle
   always_ff @(posedge clk) begin
      if (write_req && !pending) begin
         adr_q <= address;
         dat_q <= data;
      end
   end

   assign wb_cyc   = active;
   assign wb_stb   = active;
   assign wb_we    = active;
   assign wb_adr   = pending ? adr_q : address;
   assign wb_dat_o = pending ? dat_q : data;
   // always a full quadword
   assign wb_sel   = '1;

   // zero wait states give zero stall cycles
   assign stall = active & ~wb_ack;

   a_ack_in_cyc: assert property (
      @(posedge clk) disable iff (!rst_n) wb_ack |-> wb_cyc
   ) else $error("dcache_write_wb: ack outside a bus cycle");

endmodule

// File: source/flags_wb.sv
module flags_wb import wb_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              ld_flags,
   input  logic              pop_flags,
   input  logic [word_w-1:0] flags_affected,
   input  logic [word_w-1:0] new_flags,
   input  logic [word_w-1:0] pop_value,
   output logic [word_w-1:0] cur_flags,
   output logic [word_w-1:0] final_flags
);

   logic [word_w-1:0] merged;

   // untouched bits keep their architectural value
   assign merged = (new_flags & flags_affected) | (cur_flags & ~flags_affected);

   always_comb begin
      if (pop_flags) begin
         final_flags = pop_value;
      end else begin
         final_flags = merged;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cur_flags <= '0;
      end else if (ld_flags) begin
         cur_flags <= final_flags;
      end
   end

   // a committed popf must also load flags in the control store
   a_pop_needs_ld: assert property (
      @(posedge clk) disable iff (!rst_n) pop_flags |-> ld_flags
   ) else $error("flags_wb: pop without flags load");

endmodule

// File: source/operand_select_wb.sv
module operand_select_wb import wb_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              capture,
   input  logic              is_cmps_first,
   input  logic              save_neip,
   input  logic              save_ncs,
   input  logic              push_flags,
   input  logic              use_temp_neip,
   input  logic              use_temp_ncs,
   input  logic              take_branch,
   input  logic              cond_branch,
   input  logic              repeat_cmps,
   input  logic [word_w-1:0] result_a,
   input  logic [word_w-1:0] result_c,
   input  logic [word_w-1:0] neip,
   input  logic [word_w-1:0] neip_not_taken,
   input  logic [seg_w-1:0]  ncs,
   input  logic [word_w-1:0] flags,
   output logic [word_w-1:0] data1,
   output logic [word_w-1:0] final_eip,
   output logic [seg_w-1:0]  final_cs,
   output logic [word_w-1:0] count
);

   logic [word_w-1:0] temp_eip;
   logic [seg_w-1:0]  temp_cs;

   // pushf and call push ahead of plain results
   always_comb begin
      if (push_flags)     data1 = flags;
      else if (save_neip) data1 = neip;
      else                data1 = result_a;
   end

   always_comb begin
      if (repeat_cmps || use_temp_neip) begin
         final_eip = temp_eip;
      end else if (cond_branch && !take_branch) begin
         final_eip = neip_not_taken;
      end else begin
         final_eip = neip;
      end
   end

   assign final_cs = use_temp_ncs ? temp_cs : ncs;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         temp_eip <= '0;
         temp_cs  <= '0;
         count    <= '0;
      end else if (capture) begin
         if (save_neip)     temp_eip <= neip;
         if (save_ncs)      temp_cs  <= ncs;
         // ecx seen by the first cmps micro-op
         if (is_cmps_first) count    <= result_c;
      end
   end

endmodule

// File: source/repne_halt_wb.sv
module repne_halt_wb import wb_pkg::*; (
   input  logic              valid,
   input  logic              is_halt,
   input  logic              is_cmps_second,
   input  logic              repne,
   input  logic [word_w-1:0] flags,
   input  logic [word_w-1:0] count,
   output logic              halt,
   output logic              repne_terminate
);

   logic count_zero;
   logic stop_cond;

   assign halt = valid & is_halt;

   // count is ecx after the decrement
   assign count_zero = (count == '0);

   // repne stops on a match or when ecx runs out
   assign stop_cond = flags[flag_zf] | count_zero;

   assign repne_terminate = valid & is_cmps_second & repne & stop_cond;

endmodule

// File: source/wb_pkg.sv
package wb_pkg;

   // datapath widths
   localparam int word_w    = 32;
   localparam int mm_w      = 64;
   localparam int cs_word_w = 128;
   localparam int seg_w     = 16;
   localparam int dr_w      = 3;

   // x86 eflags positions
   localparam int flag_cf = 0;
   localparam int flag_zf = 6;

   // control-store single-bit fields
   localparam int cs_ld_gpr3        = 0;
   localparam int cs_ld_seg         = 1;
   localparam int cs_ld_mm          = 2;
   localparam int cs_ld_flags       = 3;
   localparam int cs_ld_eip         = 4;
   localparam int cs_ld_cs          = 5;
   localparam int cs_pop_flags      = 6;
   localparam int cs_push_flags     = 7;
   localparam int cs_save_neip      = 8;
   localparam int cs_save_ncs       = 9;
   localparam int cs_use_temp_neip  = 10;
   localparam int cs_use_temp_ncs   = 11;
   localparam int cs_is_jne         = 12;
   localparam int cs_is_jnbe        = 13;
   localparam int cs_is_cmovc       = 14;
   localparam int cs_is_cmps_first  = 15;
   localparam int cs_is_cmps_second = 16;
   localparam int cs_is_halt        = 17;
   localparam int cs_mm_mem         = 18;

   // multi-bit fields, lsb positions
   localparam int cs_dr3_lsb            = 20;
   localparam int cs_flags_affected_lsb = 32;

   // port 3 always writes a doubleword
   localparam logic [1:0] dr3_datasize = 2'b10;

endpackage

// File: source/writeback.sv
module writeback import wb_pkg::*; (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 wb_v,
   input  logic [cs_word_w-1:0] control_store,
   input  logic [word_w-1:0]    neip,
   input  logic [word_w-1:0]    neip_not_taken,
   input  logic [seg_w-1:0]     ncs,
   input  logic [1:0]           datasize,
   input  logic                 ex_ld_gpr1,
   input  logic                 ex_ld_gpr2,
   input  logic                 ex_dcache_write,
   input  logic                 repne,
   input  logic [word_w-1:0]    result_a,
   input  logic [word_w-1:0]    result_b,
   input  logic [word_w-1:0]    result_c,
   input  logic [mm_w-1:0]      result_mm,
   input  logic [word_w-1:0]    flags_in,
   input  logic [dr_w-1:0]      dr1,
   input  logic [dr_w-1:0]      dr2,
   input  logic [word_w-1:0]    address,
   input  logic                 wb_ack,
   output logic [dr_w-1:0]      final_dr1,
   output logic [dr_w-1:0]      final_dr2,
   output logic [dr_w-1:0]      final_dr3,
   output logic [word_w-1:0]    final_data1,
   output logic [word_w-1:0]    final_data2,
   output logic [word_w-1:0]    final_data3,
   output logic                 ld_gpr1,
   output logic                 ld_gpr2,
   output logic                 ld_gpr3,
   output logic [1:0]           final_datasize,
   output logic [1:0]           dr3_datasize_out,
   output logic                 ld_seg,
   output logic [mm_w-1:0]      mm_data,
   output logic                 ld_mm,
   output logic [word_w-1:0]    final_eip,
   output logic                 ld_eip,
   output logic [seg_w-1:0]     final_cs,
   output logic                 ld_cs,
   output logic [word_w-1:0]    final_flags,
   output logic                 ld_flags,
   output logic                 wb_cyc,
   output logic                 wb_stb,
   output logic                 wb_we,
   output logic [word_w-1:0]    wb_adr,
   output logic [mm_w-1:0]      wb_dat_o,
   output logic [mm_w/8-1:0]    wb_sel,
   output logic                 dep_ld_gpr1,
   output logic                 dep_ld_gpr2,
   output logic                 dep_ld_gpr3,
   output logic                 dep_ld_seg,
   output logic                 dep_ld_mm,
   output logic                 dep_dcache_write,
   output logic                 halt,
   output logic                 repne_terminate,
   output logic                 stall,
   output logic                 branch_taken,
   output logic [word_w-1:0]    flags_fwd,
   output logic [word_w-1:0]    count_fwd
);

   logic              is_jne, is_jnbe, is_cmovc;
   logic              is_cmps_first, is_cmps_second;
   logic [word_w-1:0] flags_affected;
   logic [word_w-1:0] cur_flags;
   logic [word_w-1:0] data1;
   logic [word_w-1:0] count;
   logic [mm_w-1:0]   dcache_data;
   logic              take_branch, cond_ld_gpr2, cond_branch, repeat_cmps;
   logic              v_ld_gpr1, v_ld_gpr2, v_ld_gpr3, v_ld_seg, v_ld_mm;
   logic              v_ld_flags, v_ld_eip, v_ld_cs, v_dcache_req, capture;

   assign is_jne         = control_store[cs_is_jne];
   assign is_jnbe        = control_store[cs_is_jnbe];
   assign is_cmovc       = control_store[cs_is_cmovc];
   assign is_cmps_first  = control_store[cs_is_cmps_first];
   assign is_cmps_second = control_store[cs_is_cmps_second];
   assign flags_affected = control_store[cs_flags_affected_lsb +: word_w];

   assign cond_branch = is_jne | is_jnbe;
   // string loop goes back to the saved eip
   assign repeat_cmps = wb_v & is_cmps_second & repne & ~repne_terminate;

   flags_wb flags_i (
      .clk(clk), .rst_n(rst_n), .ld_flags(v_ld_flags),
      // only a committing popf selects the popped value
      .pop_flags(control_store[cs_pop_flags] & capture),
      .flags_affected(flags_affected), .new_flags(flags_in), .pop_value(result_a),
      .cur_flags(cur_flags), .final_flags(final_flags)
   );

   branch_resolve_wb branch_i (
      .flags(cur_flags), .is_jne(is_jne), .is_jnbe(is_jnbe), .is_cmovc(is_cmovc),
      .ex_ld_gpr2(ex_ld_gpr2), .take_branch(take_branch), .cond_ld_gpr2(cond_ld_gpr2)
   );

   repne_halt_wb repne_i (
      .valid(wb_v), .is_halt(control_store[cs_is_halt]), .is_cmps_second(is_cmps_second),
      .repne(repne), .flags(cur_flags), .count(result_c),
      .halt(halt), .repne_terminate(repne_terminate)
   );

   operand_select_wb operand_i (
      .clk(clk), .rst_n(rst_n), .capture(capture), .is_cmps_first(is_cmps_first),
      .save_neip(control_store[cs_save_neip]), .save_ncs(control_store[cs_save_ncs]),
      .push_flags(control_store[cs_push_flags]),
      .use_temp_neip(control_store[cs_use_temp_neip]),
      .use_temp_ncs(control_store[cs_use_temp_ncs]),
      .take_branch(take_branch), .cond_branch(cond_branch), .repeat_cmps(repeat_cmps),
      .result_a(result_a), .result_c(result_c), .neip(neip),
      .neip_not_taken(neip_not_taken), .ncs(ncs), .flags(cur_flags),
      .data1(data1), .final_eip(final_eip), .final_cs(final_cs), .count(count)
   );

   commit_validate_wb commit_i (
      .valid(wb_v), .stall(stall), .repne_terminate(repne_terminate),
      .is_cmps_second(is_cmps_second), .ex_ld_gpr1(ex_ld_gpr1),
      .cond_ld_gpr2(cond_ld_gpr2), .ex_dcache_write(ex_dcache_write),
      .ld_gpr3(control_store[cs_ld_gpr3]), .ld_seg(control_store[cs_ld_seg]),
      .ld_mm(control_store[cs_ld_mm]), .ld_flags(control_store[cs_ld_flags]),
      .ld_eip(control_store[cs_ld_eip]), .ld_cs(control_store[cs_ld_cs]),
      .v_ld_gpr1(v_ld_gpr1), .v_ld_gpr2(v_ld_gpr2), .v_ld_gpr3(v_ld_gpr3),
      .v_ld_seg(v_ld_seg), .v_ld_mm(v_ld_mm), .v_ld_flags(v_ld_flags),
      .v_ld_eip(v_ld_eip), .v_ld_cs(v_ld_cs), .v_dcache_req(v_dcache_req),
      .capture(capture)
   );

   // mmx stores write the full quadword
   assign dcache_data = control_store[cs_mm_mem] ? result_mm : {{(mm_w-word_w){1'b0}}, data1};

   dcache_write_wb dcache_i (
      .clk(clk), .rst_n(rst_n), .write_req(v_dcache_req), .address(address),
      .data(dcache_data), .stall(stall), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
      .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_o(wb_dat_o), .wb_sel(wb_sel),
      .wb_ack(wb_ack)
   );

   assign final_dr1        = dr1;
   assign final_dr2        = dr2;
   assign final_dr3        = control_store[cs_dr3_lsb +: dr_w];
   assign final_data1      = data1;
   assign final_data2      = result_b;
   assign final_data3      = result_c;
   assign final_datasize   = datasize;
   assign dr3_datasize_out = dr3_datasize;
   assign mm_data          = result_mm;

   assign ld_gpr1  = v_ld_gpr1;
   assign ld_gpr2  = v_ld_gpr2;
   assign ld_gpr3  = v_ld_gpr3;
   assign ld_seg   = v_ld_seg;
   assign ld_mm    = v_ld_mm;
   assign ld_eip   = v_ld_eip;
   assign ld_cs    = v_ld_cs;
   assign ld_flags = v_ld_flags;

   // hazard unit view
   assign dep_ld_gpr1      = v_ld_gpr1;
   assign dep_ld_gpr2      = v_ld_gpr2;
   assign dep_ld_gpr3      = v_ld_gpr3;
   assign dep_ld_seg       = v_ld_seg;
   assign dep_ld_mm        = v_ld_mm;
   assign dep_dcache_write = v_dcache_req;

   assign branch_taken = take_branch;
   assign flags_fwd    = final_flags;
   assign count_fwd    = count;

endmodule

// File: testbench/writeback_tb.sv
module writeback_tb import wb_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int n_flag_ops  = 40;
   localparam int n_cache_ops = 30;
   // roughly four times the longest run with four cycles per store at worst
   localparam int max_cycles  = 4 * (n_flag_ops + 4 * n_cache_ops + 100);

   typedef struct packed {
      logic                 v;
      logic [cs_word_w-1:0] ctrl;
      logic [word_w-1:0]    neip;
      logic [word_w-1:0]    neip_nt;
      logic [seg_w-1:0]     ncs;
      logic                 gpr1;
      logic                 gpr2;
      logic                 dw;
      logic                 repne;
      logic [word_w-1:0]    ra;
      logic [word_w-1:0]    rb;
      logic [word_w-1:0]    rc;
      logic [mm_w-1:0]      rmm;
      logic [word_w-1:0]    flags_in;
      logic [word_w-1:0]    address;
      logic [dr_w-1:0]      dr1;
      logic [dr_w-1:0]      dr2;
      logic [1:0]           dsize;
   } uop_t;

   typedef struct packed {
      logic [word_w-1:0] eip;
      logic [word_w-1:0] data1;
      logic [word_w-1:0] flags;
      logic [seg_w-1:0]  cs;
      logic [7:0]        loads;
      logic              term;
      logic              taken;
      logic              halt;
      logic [mm_w-1:0]   ddata;
   } exp_t;

   logic                 clk, rst_n, wb_v, wb_ack, repne;
   logic [cs_word_w-1:0] control_store;
   logic [word_w-1:0]    neip, neip_not_taken, result_a, result_b, result_c, flags_in, address;
   logic [seg_w-1:0]     ncs;
   logic [1:0]           datasize;
   logic                 ex_ld_gpr1, ex_ld_gpr2, ex_dcache_write;
   logic [mm_w-1:0]      result_mm;
   logic [dr_w-1:0]      dr1, dr2, final_dr1, final_dr2, final_dr3;
   logic [word_w-1:0]    final_data1, final_data2, final_data3, final_eip, final_flags;
   logic [1:0]           final_datasize, dr3_datasize_out;
   logic                 ld_gpr1, ld_gpr2, ld_gpr3, ld_seg, ld_mm, ld_eip, ld_cs, ld_flags;
   logic [mm_w-1:0]      mm_data, wb_dat_o;
   logic [seg_w-1:0]     final_cs;
   logic                 wb_cyc, wb_stb, wb_we;
   logic [word_w-1:0]    wb_adr, flags_fwd, count_fwd;
   logic [mm_w/8-1:0]    wb_sel;
   logic                 dep_ld_gpr1, dep_ld_gpr2, dep_ld_gpr3, dep_ld_seg, dep_ld_mm;
   logic                 dep_dcache_write, halt, repne_terminate, stall, branch_taken;

   // reference state
   logic [word_w-1:0] m_flags, m_temp_eip, m_count;
   logic [seg_w-1:0]  m_temp_cs;

   uop_t         cur;
   bit           op_busy = 1'b0;
   int           seed = 65;
   int           stall_cycles, last_waits, cycles;
   int           errors, checks, tests_run, errors_at_start;
   string        test_name;
   logic [104:0] bus_log[$];

   writeback writeback_i (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      cycles = 0;
      while (cycles < max_cycles) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: no result after %0d cycles", max_cycles);
      $display("Test failures found");
      $finish;
   end

   // wishbone slave with 0 to 3 wait states per write
   initial begin : slave_model
      int cnt;
      bit busy;
      wb_ack = 1'b0;
      busy = 1'b0;
      cnt = 0;
      forever begin
         @(posedge clk);
         #2;
         wb_ack = 1'b0;
         if (wb_cyc && wb_stb) begin
            if (!busy) begin
               busy = 1'b1;
               cnt = 0;
               last_waits = $unsigned($random(seed)) % 4;
            end
            if (cnt == last_waits) begin
               wb_ack = 1'b1;
               busy = 1'b0;
               bus_log.push_back({wb_we, wb_sel, wb_adr, wb_dat_o});
            end else begin
               cnt++;
            end
         end
      end
   end

   function automatic exp_t expected_result(uop_t u);
      exp_t e;
      logic cf, zf, cond, again, g2;
      logic [word_w-1:0] mask;
      cf = m_flags[flag_cf];
      zf = m_flags[flag_zf];
      mask = u.ctrl[cs_flags_affected_lsb +: word_w];
      cond = u.ctrl[cs_is_jne] | u.ctrl[cs_is_jnbe];
      e.taken = (u.ctrl[cs_is_jne] & ~zf) | (u.ctrl[cs_is_jnbe] & ~cf & ~zf);
      e.halt = u.v & u.ctrl[cs_is_halt];
      // repne cmps ends on equal operands or when ecx is used up
      e.term = u.v & u.ctrl[cs_is_cmps_second] & u.repne & (zf | (u.rc == '0));
      again = u.v & u.ctrl[cs_is_cmps_second] & u.repne & ~e.term;
      if (u.ctrl[cs_push_flags]) e.data1 = m_flags;
      else if (u.ctrl[cs_save_neip]) e.data1 = u.neip;
      else e.data1 = u.ra;
      if (again || u.ctrl[cs_use_temp_neip]) e.eip = m_temp_eip;
      else if (cond && !e.taken) e.eip = u.neip_nt;
      else e.eip = u.neip;
      e.cs = u.ctrl[cs_use_temp_ncs] ? m_temp_cs : u.ncs;
      if (u.v && u.ctrl[cs_pop_flags]) e.flags = u.ra;
      else e.flags = (u.flags_in & mask) | (m_flags & ~mask);
      g2 = u.ctrl[cs_is_cmovc] ? (u.gpr2 & cf) : u.gpr2;
      e.loads = {u.gpr1 & ~e.term, g2 & ~e.term, u.ctrl[cs_ld_gpr3],
                 u.ctrl[cs_ld_seg] & ~e.term, u.ctrl[cs_ld_mm] & ~e.term,
                 u.ctrl[cs_ld_flags], u.ctrl[cs_ld_eip], u.ctrl[cs_ld_cs]};
      if (!u.v) e.loads = '0;
      e.ddata = u.ctrl[cs_mm_mem] ? u.rmm : {32'h0, e.data1};
      return e;
   endfunction

   task automatic update_model(uop_t u, exp_t e);
      if (e.loads[2]) m_flags = e.flags;
      if (u.v && u.ctrl[cs_save_neip]) m_temp_eip = u.neip;
      if (u.v && u.ctrl[cs_save_ncs]) m_temp_cs = u.ncs;
      if (u.v && u.ctrl[cs_is_cmps_first]) m_count = u.rc;
   endtask

   function automatic logic [7:0] load_vector();
      return {ld_gpr1, ld_gpr2, ld_gpr3, ld_seg, ld_mm, ld_flags, ld_eip, ld_cs};
   endfunction

   task automatic compare_value(string what, logic [63:0] exp, logic [63:0] act);
      checks++;
      assert (act === exp) else begin
         $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
         errors++;
      end
   endtask

   task automatic report_problem(string msg);
      $display("ERROR in %s: %s", test_name, msg);
      errors++;
   endtask

   task automatic check_bus(exp_t e);
      logic [104:0] entry;
      if (cur.v && cur.dw) begin
         compare_value("wait states", 64'(last_waits), 64'(stall_cycles));
         assert (bus_log.size() == 1)
            else report_problem($sformatf("%0d bus writes for one store", bus_log.size()));
         if (bus_log.size() > 0) begin
            entry = bus_log.pop_front();
            compare_value("bus we", 64'h1, 64'(entry[104]));
            compare_value("bus sel", 64'hff, 64'(entry[103:96]));
            compare_value("bus address", 64'(cur.address), 64'(entry[95:64]));
            compare_value("bus data", e.ddata, entry[63:0]);
         end
      end else begin
         assert (bus_log.size() == 0) else report_problem("bus write without a store micro-op");
      end
      bus_log.delete();
   endtask

   initial begin : compare_proc
      exp_t e;
      forever begin
         @(negedge clk);
         if (op_busy) begin
            if (stall) begin
               stall_cycles++;
               assert (cur.v && cur.dw) else report_problem("stall raised without a store");
               compare_value("loads while stalled", 64'h0, 64'(load_vector()));
               compare_value("bus cycle while stalled", 64'h1, 64'(wb_cyc & wb_stb & wb_we));
            end else begin
               e = expected_result(cur);
               compare_value("final_eip", 64'(e.eip), 64'(final_eip));
               compare_value("final_data1", 64'(e.data1), 64'(final_data1));
               compare_value("final_flags", 64'(e.flags), 64'(final_flags));
               compare_value("flags_fwd", 64'(e.flags), 64'(flags_fwd));
               compare_value("final_cs", 64'(e.cs), 64'(final_cs));
               compare_value("loads", 64'(e.loads), 64'(load_vector()));
               compare_value("dep bits", 64'(e.loads[7:3]),
                  64'({dep_ld_gpr1, dep_ld_gpr2, dep_ld_gpr3, dep_ld_seg, dep_ld_mm}));
               compare_value("dep_dcache_write", 64'(cur.v & cur.dw), 64'(dep_dcache_write));
               compare_value("repne_terminate", 64'(e.term), 64'(repne_terminate));
               compare_value("branch_taken", 64'(e.taken), 64'(branch_taken));
               compare_value("halt", 64'(e.halt), 64'(halt));
               compare_value("count_fwd", 64'(m_count), 64'(count_fwd));
               compare_value("final_dr1", 64'(cur.dr1), 64'(final_dr1));
               compare_value("final_dr2", 64'(cur.dr2), 64'(final_dr2));
               compare_value("final_dr3", 64'(cur.ctrl[cs_dr3_lsb +: dr_w]), 64'(final_dr3));
               compare_value("final_data2", 64'(cur.rb), 64'(final_data2));
               compare_value("final_data3", 64'(cur.rc), 64'(final_data3));
               compare_value("final_datasize", 64'(cur.dsize), 64'(final_datasize));
               // port 3 is always a doubleword
               compare_value("dr3 datasize", 64'(2'b10), 64'(dr3_datasize_out));
               compare_value("mm_data", cur.rmm, mm_data);
               check_bus(e);
               update_model(cur, e);
               op_busy = 1'b0;
            end
         end
      end
   end

   task automatic apply_inputs(uop_t u);
      wb_v = u.v;
      control_store = u.ctrl;
      neip = u.neip;
      neip_not_taken = u.neip_nt;
      ncs = u.ncs;
      ex_ld_gpr1 = u.gpr1;
      ex_ld_gpr2 = u.gpr2;
      ex_dcache_write = u.dw;
      repne = u.repne;
      result_a = u.ra;
      result_b = u.rb;
      result_c = u.rc;
      result_mm = u.rmm;
      flags_in = u.flags_in;
      address = u.address;
      dr1 = u.dr1;
      dr2 = u.dr2;
      datasize = u.dsize;
   endtask

   // drive one micro-op and hold it until it commits
   task automatic run_op(uop_t u);
      // pass-through fields get fresh values for every micro-op
      u.dr1 = dr_w'($random(seed));
      u.dr2 = dr_w'($random(seed));
      u.dsize = 2'($random(seed));
      u.rb = $random(seed);
      u.ctrl[cs_dr3_lsb +: dr_w] = dr_w'($random(seed));
      @(posedge clk);
      #1;
      apply_inputs(u);
      cur = u;
      stall_cycles = 0;
      op_busy = 1'b1;
      wait (!op_busy);
   endtask

   task automatic load_flags(logic [word_w-1:0] value);
      uop_t u;
      u = '0;
      u.v = 1'b1;
      u.ctrl[cs_ld_flags] = 1'b1;
      u.ctrl[cs_flags_affected_lsb +: word_w] = '1;
      u.flags_in = value;
      run_op(u);
   endtask

   task automatic start_test(string name);
      test_name = name;
      errors_at_start = errors;
   endtask

   task automatic finish_test();
      tests_run++;
      if (errors == errors_at_start) $display("test %s: ok", test_name);
      else $display("test %s: %0d mismatches", test_name, errors - errors_at_start);
   endtask

   initial begin : main
      uop_t u;
      logic [word_w-1:0] fl;
      errors = 0;
      checks = 0;
      tests_run = 0;
      m_flags = '0;
      m_temp_eip = '0;
      m_temp_cs = '0;
      m_count = '0;
      apply_inputs('0);
      rst_n = 1'b0;
      repeat (2) @(posedge clk);
      #1 rst_n = 1'b1;

      start_test("flags merge and pop");
      repeat (n_flag_ops) begin
         u = '0;
         u.v = 1'b1;
         u.ctrl[cs_flags_affected_lsb +: word_w] = $random(seed);
         u.flags_in = $random(seed);
         u.ra = $random(seed);
         u.ctrl[cs_ld_flags] = ($random(seed) % 4) != 0;
         // popf always comes with a flags load
         if (u.ctrl[cs_ld_flags] && ($random(seed) % 3 == 0)) u.ctrl[cs_pop_flags] = 1'b1;
         run_op(u);
      end
      finish_test();

      start_test("conditional branches");
      for (int c = 0; c < 4; c++) begin
         fl = '0;
         fl[flag_cf] = c[0];
         fl[flag_zf] = c[1];
         load_flags(fl);
         for (int k = 0; k < 3; k++) begin
            u = '0;
            u.v = 1'b1;
            u.neip = $random(seed);
            u.neip_nt = $random(seed);
            u.ctrl[cs_ld_eip] = 1'b1;
            case (k)
               0: u.ctrl[cs_is_jne] = 1'b1;
               1: u.ctrl[cs_is_jnbe] = 1'b1;
               default: begin
                  u.ctrl[cs_is_cmovc] = 1'b1;
                  u.gpr2 = 1'b1;
               end
            endcase
            run_op(u);
         end
      end
      finish_test();

      start_test("data1 sources");
      load_flags($random(seed));
      for (int k = 0; k < 4; k++) begin
         u = '0;
         u.v = 1'b1;
         u.dw = 1'b1;
         u.gpr1 = 1'b1;
         u.ra = $random(seed);
         u.neip = $random(seed);
         u.rmm = {$random(seed), $random(seed)};
         u.address = $random(seed);
         case (k)
            0: u.ctrl[cs_push_flags] = 1'b1;
            1: u.ctrl[cs_save_neip] = 1'b1;
            3: u.ctrl[cs_mm_mem] = 1'b1;
            default: ;
         endcase
         run_op(u);
      end
      finish_test();

      start_test("repne cmps");
      // repeat, stop on zf, stop on ecx zero
      for (int k = 0; k < 3; k++) begin
         fl = '0;
         fl[flag_zf] = (k == 1);
         load_flags(fl);
         u = '0;
         u.v = 1'b1;
         u.ctrl[cs_is_cmps_first] = 1'b1;
         u.ctrl[cs_save_neip] = 1'b1;
         u.ctrl[cs_save_ncs] = 1'b1;
         u.ctrl[cs_ld_gpr3] = 1'b1;
         u.neip = $random(seed);
         u.ncs = 16'h0023;
         u.rc = 32'd5;
         run_op(u);
         u = '0;
         u.v = 1'b1;
         u.repne = 1'b1;
         u.gpr1 = 1'b1;
         u.ctrl[cs_is_cmps_second] = 1'b1;
         u.ctrl[cs_ld_gpr3] = 1'b1;
         u.ctrl[cs_ld_flags] = 1'b1;
         u.ctrl[cs_ld_eip] = 1'b1;
         u.ctrl[cs_use_temp_ncs] = 1'b1;
         u.neip = $random(seed);
         u.rc = (k == 2) ? 32'd0 : 32'd4;
         run_op(u);
      end
      finish_test();

      start_test("cache write");
      repeat (n_cache_ops) begin
         u = '0;
         u.v = 1'b1;
         u.dw = 1'b1;
         u.gpr1 = 1'b1;
         u.ctrl[cs_ld_gpr3] = ($random(seed) % 2) != 0;
         u.ctrl[cs_mm_mem] = ($random(seed) % 2) != 0;
         u.ra = $random(seed);
         u.rmm = {$random(seed), $random(seed)};
         u.address = $random(seed);
         run_op(u);
      end
      finish_test();

      start_test("halt and invalid");
      u = '0;
      u.v = 1'b1;
      u.ctrl[cs_is_halt] = 1'b1;
      run_op(u);
      for (int k = 0; k < 8; k++) begin
         u = '0;
         u.ctrl = {$random(seed), $random(seed), $random(seed), $random(seed)};
         u.ctrl[cs_is_jnbe] = 1'b0;
         u.ctrl[cs_is_halt] = (k < 2);
         u.gpr1 = 1'b1;
         u.gpr2 = 1'b1;
         u.dw = 1'b1;
         u.repne = 1'b1;
         u.neip = $random(seed);
         u.neip_nt = $random(seed);
         u.ra = $random(seed);
         u.flags_in = $random(seed);
         run_op(u);
      end
      finish_test();

      $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule
